// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - include_dirs:
      - .
    files:
      - cpu_pkg.sv
      - cpu_ctrl_if.sv
      - cpu_fetch.sv
      - cpu_decoder.sv
      - cpu_regfile.sv
      - cpu_exec.sv
      - cpu_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_cpu.sv

// ==== cpu_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

interface cpu_ctrl_if;

	logic                           valid;
	logic [`CPU_XLEN-1:0]           pc;
	cpu_pkg::alu_op_e               alu_op;
	logic                           use_imm;
	logic [`CPU_XLEN-1:0]           imm;
	logic [`CPU_REG_ADDR_W-1:0]     rd;
	logic                           rd_we;
	cpu_pkg::branch_kind_e          branch_kind;
	logic                           illegal;

	modport decode (
		output valid, pc, alu_op, use_imm, imm, rd, rd_we, branch_kind, illegal
	);

	modport exec (
		input valid, pc, alu_op, use_imm, imm, rd, rd_we, branch_kind, illegal
	);

endinterface

`default_nettype wire

// ==== cpu_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module cpu_decoder (
	input  wire  [`CPU_XLEN-1:0]         inst_i,
	input  wire  [`CPU_XLEN-1:0]         pc_i,
	input  wire                          exec_i,
	output logic [`CPU_REG_ADDR_W-1:0]   rs1_addr_o,
	output logic [`CPU_REG_ADDR_W-1:0]   rs2_addr_o,
	cpu_ctrl_if.decode                   ctrl
);

	logic [2:0]               funct3;
	logic [6:0]               funct7;
	logic [`CPU_XLEN-1:0]     imm_i_type;
	logic [`CPU_XLEN-1:0]     imm_u_type;
	logic [`CPU_XLEN-1:0]     imm_b_type;
	logic [`CPU_XLEN-1:0]     imm_j_type;
	cpu_pkg::alu_op_e         alu_op;
	cpu_pkg::branch_kind_e    branch_kind;
	logic                     use_imm;
	logic                     writes_rd;
	logic                     illegal;
	logic [`CPU_XLEN-1:0]     imm;

	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];

	assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_u_type = {inst_i[31:12], 12'b0};
	assign imm_b_type = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
		inst_i[11:8], 1'b0};
	assign imm_j_type = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
		inst_i[30:21], 1'b0};

	always_comb begin
		alu_op      = cpu_pkg::ALU_ADD;
		branch_kind = cpu_pkg::BR_NONE;
		use_imm     = 1'b0;
		writes_rd   = 1'b0;
		illegal     = 1'b0;
		imm         = imm_i_type;
		case (cpu_pkg::opcode_e'(inst_i[6:0]))
			cpu_pkg::OPC_OP_IMM: begin
				use_imm   = 1'b1;
				writes_rd = 1'b1;
				case (funct3)
					3'b000: alu_op = cpu_pkg::ALU_ADD;
					3'b100: alu_op = cpu_pkg::ALU_XOR;
					3'b110: alu_op = cpu_pkg::ALU_OR;
					3'b111: alu_op = cpu_pkg::ALU_AND;
					default: illegal = 1'b1;
				endcase
			end
			cpu_pkg::OPC_OP: begin
				writes_rd = 1'b1;
				if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
					alu_op = cpu_pkg::ALU_SUB;
				end else if (funct7 == 7'b0000000) begin
					case (funct3)
						3'b000: alu_op = cpu_pkg::ALU_ADD;
						3'b100: alu_op = cpu_pkg::ALU_XOR;
						3'b110: alu_op = cpu_pkg::ALU_OR;
						3'b111: alu_op = cpu_pkg::ALU_AND;
						default: illegal = 1'b1;
					endcase
				end else begin
					illegal = 1'b1;
				end
			end
			cpu_pkg::OPC_LUI: begin
				alu_op    = cpu_pkg::ALU_PASS_B;
				use_imm   = 1'b1;
				writes_rd = 1'b1;
				imm       = imm_u_type;
			end
			cpu_pkg::OPC_BRANCH: begin
				imm = imm_b_type;
				case (funct3)
					3'b000: branch_kind = cpu_pkg::BR_EQ;
					3'b001: branch_kind = cpu_pkg::BR_NE;
					default: illegal = 1'b1;
				endcase
			end
			cpu_pkg::OPC_JAL: begin
				branch_kind = cpu_pkg::BR_JUMP;
				writes_rd   = 1'b1;
				imm         = imm_j_type;
			end
			default: illegal = 1'b1;
		endcase
		// anything unrecognised retires as a plain fall-through
		if (illegal) begin
			writes_rd   = 1'b0;
			branch_kind = cpu_pkg::BR_NONE;
		end
	end

	assign rs1_addr_o = inst_i[19:15];
	assign rs2_addr_o = inst_i[24:20];

	assign ctrl.valid       = exec_i;
	assign ctrl.pc          = pc_i;
	assign ctrl.alu_op      = alu_op;
	assign ctrl.use_imm     = use_imm;
	assign ctrl.imm         = imm;
	assign ctrl.rd          = inst_i[11:7];
	// x0 is never a real destination
	assign ctrl.rd_we       = writes_rd && (inst_i[11:7] != '0);
	assign ctrl.branch_kind = branch_kind;
	assign ctrl.illegal     = illegal;

endmodule

`default_nettype wire

// ==== cpu_exec.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module cpu_exec (
	cpu_ctrl_if.exec                     ctrl,
	input  wire  [`CPU_XLEN-1:0]         rs1_data_i,
	input  wire  [`CPU_XLEN-1:0]         rs2_data_i,
	output logic [`CPU_XLEN-1:0]         next_pc_o,
	output logic                         rf_we_o,
	output logic [`CPU_REG_ADDR_W-1:0]   rf_addr_o,
	output logic [`CPU_XLEN-1:0]         rf_data_o,
	output logic                         retire_valid_o,
	output logic [`CPU_XLEN-1:0]         retire_pc_o,
	output logic [`CPU_REG_ADDR_W-1:0]   retire_rd_o,
	output logic [`CPU_XLEN-1:0]         retire_wdata_o,
	output logic                         retire_illegal_o
);

	logic [`CPU_XLEN-1:0] operand_b;
	logic [`CPU_XLEN-1:0] alu_result;
	logic [`CPU_XLEN-1:0] link_pc;
	logic                 taken;

	assign operand_b = ctrl.use_imm ? ctrl.imm : rs2_data_i;
	assign link_pc   = ctrl.pc + 'd4;

	always_comb begin
		case (ctrl.alu_op)
			cpu_pkg::ALU_ADD:    alu_result = rs1_data_i + operand_b;
			cpu_pkg::ALU_SUB:    alu_result = rs1_data_i - operand_b;
			cpu_pkg::ALU_AND:    alu_result = rs1_data_i & operand_b;
			cpu_pkg::ALU_OR:     alu_result = rs1_data_i | operand_b;
			cpu_pkg::ALU_XOR:    alu_result = rs1_data_i ^ operand_b;
			cpu_pkg::ALU_PASS_B: alu_result = operand_b;
			default:             alu_result = '0;
		endcase
	end

	// branch compare always uses rs2, never the immediate
	always_comb begin
		case (ctrl.branch_kind)
			cpu_pkg::BR_EQ:   taken = (rs1_data_i == rs2_data_i);
			cpu_pkg::BR_NE:   taken = (rs1_data_i != rs2_data_i);
			cpu_pkg::BR_JUMP: taken = 1'b1;
			default:          taken = 1'b0;
		endcase
	end

	assign next_pc_o = taken ? (ctrl.pc + ctrl.imm) : link_pc;

	assign rf_we_o   = ctrl.valid && ctrl.rd_we;
	assign rf_addr_o = ctrl.rd;
	// jal writes the return address instead of the alu result
	assign rf_data_o = (ctrl.branch_kind == cpu_pkg::BR_JUMP) ? link_pc : alu_result;

	assign retire_valid_o   = ctrl.valid;
	assign retire_pc_o      = ctrl.pc;
	assign retire_rd_o      = rf_we_o ? ctrl.rd : '0;
	assign retire_wdata_o   = rf_we_o ? rf_data_o : '0;
	assign retire_illegal_o = ctrl.valid && ctrl.illegal;

	always_comb begin
		assert final (!(retire_illegal_o && rf_we_o))
			else $error("illegal instruction retired with a register write");
	end

endmodule

`default_nettype wire

// ==== cpu_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module cpu_fetch (
	input  wire                    clock,
	input  wire                    reset_i,
	input  wire                    inst_valid_i,
	input  wire  [`CPU_XLEN-1:0]   inst_rdata_i,
	input  wire  [`CPU_XLEN-1:0]   next_pc_i,
	output logic                   inst_req_o,
	output logic [`CPU_XLEN-1:0]   inst_addr_o,
	output logic [`CPU_XLEN-1:0]   inst_o,
	output logic [`CPU_XLEN-1:0]   pc_o,
	output logic                   exec_o
);

	cpu_pkg::fetch_state_e  state_q;
	logic [`CPU_XLEN-1:0]   pc_q;
	logic [`CPU_XLEN-1:0]   inst_q;

	always_ff @(posedge clock) begin
		if (reset_i) begin
			state_q <= cpu_pkg::FETCH_IDLE;
			pc_q    <= `CPU_RESET_PC;
		end else begin
			case (state_q)
				cpu_pkg::FETCH_IDLE: begin
					state_q <= cpu_pkg::FETCH_REQUEST;
				end
				// hold the request until memory answers
				cpu_pkg::FETCH_REQUEST: begin
					if (inst_valid_i) begin
						state_q <= cpu_pkg::FETCH_EXECUTE;
					end
				end
				// single cycle, execute result picks the next pc
				cpu_pkg::FETCH_EXECUTE: begin
					state_q <= cpu_pkg::FETCH_REQUEST;
					pc_q    <= next_pc_i;
				end
				default: begin
					state_q <= cpu_pkg::FETCH_IDLE;
				end
			endcase
		end
	end

	// capture the returned word on the accepting edge
	always_ff @(posedge clock) begin
		if (state_q == cpu_pkg::FETCH_REQUEST && inst_valid_i) begin
			inst_q <= inst_rdata_i;
		end
	end

	assign inst_req_o  = (state_q == cpu_pkg::FETCH_REQUEST);
	assign exec_o      = (state_q == cpu_pkg::FETCH_EXECUTE);
	assign inst_addr_o = pc_q;
	assign pc_o        = pc_q;
	assign inst_o      = inst_q;

	// memory may stall, the address must not move meanwhile
	property p_addr_held;
		@(posedge clock) disable iff (reset_i)
		(inst_req_o && !inst_valid_i) |=> $stable(inst_addr_o);
	endproperty
	assert property (p_addr_held)
		else $error("instruction address changed during a pending request");

endmodule

`default_nettype wire

// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	// fetch sequencing, one instruction in flight at most
	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_REQUEST,
		FETCH_EXECUTE
	} fetch_state_e;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_LUI    = 7'b0110111,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		// operand b straight through, used by lui
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {
		BR_NONE,
		BR_EQ,
		BR_NE,
		BR_JUMP
	} branch_kind_e;

endpackage

`default_nettype wire

// ==== cpu_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module cpu_regfile (
	input  wire                          clock,
	input  wire                          reset_i,
	input  wire  [`CPU_REG_ADDR_W-1:0]   rs1_addr_i,
	input  wire  [`CPU_REG_ADDR_W-1:0]   rs2_addr_i,
	input  wire                          we_i,
	input  wire  [`CPU_REG_ADDR_W-1:0]   rd_addr_i,
	input  wire  [`CPU_XLEN-1:0]         rd_data_i,
	output logic [`CPU_XLEN-1:0]         rs1_data_o,
	output logic [`CPU_XLEN-1:0]         rs2_data_o
);

	logic [`CPU_XLEN-1:0] regs [`CPU_REG_COUNT];

	always_ff @(posedge clock) begin
		if (reset_i) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i) begin
			regs[rd_addr_i] <= rd_data_i;
		end
	end

	// x0 reads as zero regardless of contents
	assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

	// decoder is expected to drop writes aimed at x0
	assert property (@(posedge clock) disable iff (reset_i) we_i |-> (rd_addr_i != '0))
		else $error("register write to x0");

endmodule

`default_nettype wire

// ==== cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath and address width, fixed by the RV32 encoding
`define CPU_XLEN 32

// integer register file
`define CPU_REG_COUNT 32
`define CPU_REG_ADDR_W 5

// first fetch address after reset
`define CPU_RESET_PC 32'h8000_0000

`endif

// ==== cpu_tests.txt ====
# name  address  instruction  expected_rd(dec)  expected_wdata(hex)  expected_illegal(dec)
# rows follow retire order; unlisted addresses hold jal x0, 0
addi_x1          80000000 12300093  1 00000123 0
addi_neg         80000004 fff00113  2 ffffffff 0
andi             80000008 0f017193  3 000000f0 0
ori              8000000c 7000e213  4 00000723 0
xori             80000010 0ff0c293  5 000001dc 0
lui              80000014 12345337  6 12345000 0
add              80000018 001303b3  7 12345123 0
sub              8000001c 40438433  8 12344a00 0
and              80000020 0033f4b3  9 00000020 0
or               80000024 0051e533 10 000001fc 0
xor              80000028 001145b3 11 fffffedc 0
add_to_x0        8000002c 00208033  0 00000000 0
read_x0          80000030 00100633 12 00000123 0
beq_taken        80000034 00c08463  0 00000000 0
bne_untaken      8000003c 00c09463  0 00000000 0
bne_taken        80000040 00209663  0 00000000 0
beq_untaken      8000004c 00208463  0 00000000 0
jal_link         80000050 010006ef 13 80000054 0
illegal_opcode   80000060 0000000b  0 00000000 1
illegal_funct7   80000064 02208733  0 00000000 1
jal_backward     80000068 ff1ff06f  0 00000000 0
addi_from_link   80000058 00468793 15 80000058 0
bne_forward      8000005c 00d79a63  0 00000000 0
sub_negative     80000070 40f68833 16 fffffffc 0
xor_mixed        80000074 00b848b3 17 00000120 0

// ==== cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module cpu_top (
	input  wire                          clock,
	input  wire                          reset_i,
	output logic                         inst_req_o,
	output logic [`CPU_XLEN-1:0]         inst_addr_o,
	input  wire                          inst_valid_i,
	input  wire  [`CPU_XLEN-1:0]         inst_rdata_i,
	output logic                         retire_valid_o,
	output logic [`CPU_XLEN-1:0]         retire_pc_o,
	output logic [`CPU_REG_ADDR_W-1:0]   retire_rd_o,
	output logic [`CPU_XLEN-1:0]         retire_wdata_o,
	output logic                         retire_illegal_o
);

	logic [`CPU_XLEN-1:0]         inst_word;
	logic [`CPU_XLEN-1:0]         cur_pc;
	logic                         exec;
	logic [`CPU_XLEN-1:0]         next_pc;
	logic [`CPU_REG_ADDR_W-1:0]   rs1_addr;
	logic [`CPU_REG_ADDR_W-1:0]   rs2_addr;
	logic [`CPU_XLEN-1:0]         rs1_data;
	logic [`CPU_XLEN-1:0]         rs2_data;
	logic                         rf_we;
	logic [`CPU_REG_ADDR_W-1:0]   rf_addr;
	logic [`CPU_XLEN-1:0]         rf_data;

	// decoded fields, decoder to execute
	cpu_ctrl_if ctrl_bus ();

	cpu_fetch u_cpu_fetch (
		.clock        (clock),
		.reset_i      (reset_i),
		.inst_valid_i (inst_valid_i),
		.inst_rdata_i (inst_rdata_i),
		.next_pc_i    (next_pc),
		.inst_req_o   (inst_req_o),
		.inst_addr_o  (inst_addr_o),
		.inst_o       (inst_word),
		.pc_o         (cur_pc),
		.exec_o       (exec)
	);

	cpu_decoder u_cpu_decoder (
		.inst_i     (inst_word),
		.pc_i       (cur_pc),
		.exec_i     (exec),
		.rs1_addr_o (rs1_addr),
		.rs2_addr_o (rs2_addr),
		.ctrl       (ctrl_bus.decode)
	);

	cpu_regfile u_cpu_regfile (
		.clock      (clock),
		.reset_i    (reset_i),
		.rs1_addr_i (rs1_addr),
		.rs2_addr_i (rs2_addr),
		.we_i       (rf_we),
		.rd_addr_i  (rf_addr),
		.rd_data_i  (rf_data),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data)
	);

	cpu_exec u_cpu_exec (
		.ctrl             (ctrl_bus.exec),
		.rs1_data_i       (rs1_data),
		.rs2_data_i       (rs2_data),
		.next_pc_o        (next_pc),
		.rf_we_o          (rf_we),
		.rf_addr_o        (rf_addr),
		.rf_data_o        (rf_data),
		.retire_valid_o   (retire_valid_o),
		.retire_pc_o      (retire_pc_o),
		.retire_rd_o      (retire_rd_o),
		.retire_wdata_o   (retire_wdata_o),
		.retire_illegal_o (retire_illegal_o)
	);

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
cpu_pkg.sv
cpu_ctrl_if.sv
cpu_fetch.sv
cpu_decoder.sv
cpu_regfile.sv
cpu_exec.sv
cpu_top.sv
tb_cpu.sv

// ==== tb_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module tb_cpu;

	localparam string TEST_FILE = "cpu_tests.txt";
	localparam int CLOCK_PERIOD = 40;
	localparam int MAX_ROWS = 64;
	localparam logic [15:0] LFSR_SEED = 16'd71;
	// jal x0, 0 keeps a runaway core parked in place
	localparam logic [`CPU_XLEN-1:0] JAL_SELF = 32'h0000_006f;

	logic                          clock;
	logic                          reset_i;
	logic                          inst_req_o;
	logic [`CPU_XLEN-1:0]          inst_addr_o;
	logic                          inst_valid_i;
	logic [`CPU_XLEN-1:0]          inst_rdata_i;
	logic                          retire_valid_o;
	logic [`CPU_XLEN-1:0]          retire_pc_o;
	logic [`CPU_REG_ADDR_W-1:0]    retire_rd_o;
	logic [`CPU_XLEN-1:0]          retire_wdata_o;
	logic                          retire_illegal_o;

	// one row per retired instruction, in retire order
	string                test_name [MAX_ROWS];
	logic [`CPU_XLEN-1:0] row_pc [MAX_ROWS];
	logic [`CPU_XLEN-1:0] row_word [MAX_ROWS];
	logic [`CPU_XLEN-1:0] row_rd [MAX_ROWS];
	logic [`CPU_XLEN-1:0] row_wdata [MAX_ROWS];
	logic [`CPU_XLEN-1:0] row_illegal [MAX_ROWS];
	int                   row_count = 0;
	logic                 load_error = 1'b0;

	int retire_index = 0;
	int mismatches = 0;
	int pass_count = 0;
	int fail_count = 0;
	int cycle_count = 0;
	int cycle_limit = 0;

	// memory model state
	logic [15:0] lfsr_state;
	logic        pending;
	logic [1:0]  wait_cycles;

	cpu_top cpu_top_inst (
		.clock            (clock),
		.reset_i          (reset_i),
		.inst_req_o       (inst_req_o),
		.inst_addr_o      (inst_addr_o),
		.inst_valid_i     (inst_valid_i),
		.inst_rdata_i     (inst_rdata_i),
		.retire_valid_o   (retire_valid_o),
		.retire_pc_o      (retire_pc_o),
		.retire_rd_o      (retire_rd_o),
		.retire_wdata_o   (retire_wdata_o),
		.retire_illegal_o (retire_illegal_o)
	);

	initial clock = 1'b0;
	always #(CLOCK_PERIOD / 2) clock = ~clock;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] next_lfsr(input logic [15:0] state);
		logic feedback;
		feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
		return {state[14:0], feedback};
	endfunction

	// sparse memory, only listed addresses hold real code
	function automatic logic [`CPU_XLEN-1:0] read_imem(input logic [`CPU_XLEN-1:0] addr);
		logic [`CPU_XLEN-1:0] word;
		word = JAL_SELF;
		for (int i = 0; i < row_count; i++) begin
			if (row_pc[i] == addr) begin
				word = row_word[i];
			end
		end
		return word;
	endfunction

	task automatic load_tests();
		int                   fd;
		int                   n;
		string                line;
		string                name;
		logic [`CPU_XLEN-1:0] addr;
		logic [`CPU_XLEN-1:0] word;
		logic [`CPU_XLEN-1:0] rd;
		logic [`CPU_XLEN-1:0] wdata;
		logic [`CPU_XLEN-1:0] illegal;
		fd = $fopen(TEST_FILE, "r");
		if (fd == 0) begin
			$display("could not open %s", TEST_FILE);
			load_error = 1'b1;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.substr(0, 0) != "#") begin
				n = $sscanf(line, "%s %h %h %d %h %d", name, addr, word, rd, wdata, illegal);
				if (n == 6 && row_count < MAX_ROWS) begin
					test_name[row_count]   = name;
					row_pc[row_count]      = addr;
					row_word[row_count]    = word;
					row_rd[row_count]      = rd;
					row_wdata[row_count]   = wdata;
					row_illegal[row_count] = illegal;
					row_count++;
				end else if (n > 0) begin
					$display("unusable line in %s: %s", TEST_FILE, line);
					load_error = 1'b1;
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic compare_value(input string name, input string field,
		input logic [`CPU_XLEN-1:0] expected, input logic [`CPU_XLEN-1:0] actual);
		if (actual !== expected) begin
			$display("Error: %s %s expected %h actual %h", name, field, expected, actual);
			mismatches++;
		end
	endtask

	task automatic check_retire(input int idx);
		int errors_before;
		errors_before = mismatches;
		compare_value(test_name[idx], "pc", row_pc[idx], retire_pc_o);
		compare_value(test_name[idx], "rd", row_rd[idx], retire_rd_o);
		compare_value(test_name[idx], "wdata", row_wdata[idx], retire_wdata_o);
		compare_value(test_name[idx], "illegal", row_illegal[idx], retire_illegal_o);
		if (mismatches == errors_before) begin
			pass_count++;
			$display("%-16s ok", test_name[idx]);
		end else begin
			fail_count++;
			$display("%-16s mismatched", test_name[idx]);
		end
	endtask

	// answers each request after 0 to 3 idle cycles
	always @(posedge clock) begin
		if (reset_i) begin
			inst_valid_i <= 1'b0;
			lfsr_state = LFSR_SEED;
			pending = 1'b0;
			wait_cycles = 2'd0;
		end else if (inst_valid_i) begin
			// word taken by the core on this edge
			inst_valid_i <= 1'b0;
			pending = 1'b0;
		end else if (inst_req_o) begin
			if (!pending) begin
				pending = 1'b1;
				lfsr_state = next_lfsr(lfsr_state);
				wait_cycles[0] = lfsr_state[0];
				lfsr_state = next_lfsr(lfsr_state);
				wait_cycles[1] = lfsr_state[0];
			end
			if (wait_cycles == 2'd0) begin
				inst_valid_i <= 1'b1;
				inst_rdata_i <= read_imem(inst_addr_o);
			end else begin
				wait_cycles = wait_cycles - 2'd1;
			end
		end
	end

	// retire outputs are settled mid-cycle
	always @(negedge clock) begin
		if (!reset_i && retire_valid_o) begin
			if (retire_index < row_count) begin
				check_retire(retire_index);
			end
			retire_index++;
		end
	end

	initial begin
		reset_i = 1'b1;
		inst_valid_i = 1'b0;
		inst_rdata_i = '0;
		load_tests();
		repeat (10) @(posedge clock);
		reset_i <= 1'b0;
		cycle_limit = row_count * 6 + 50;
		while (!load_error && retire_index < row_count && cycle_count < cycle_limit) begin
			@(posedge clock);
			cycle_count++;
		end
		if (!load_error && retire_index < row_count) begin
			$display("timeout: only %0d of %0d instructions retired in %0d cycles",
				retire_index, row_count, cycle_limit);
		end
		$display("summary: %0d passed, %0d mismatched, %0d expected", pass_count,
			fail_count, row_count);
		if (!load_error && row_count > 0 && pass_count == row_count && fail_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
